//--- design/vga_pkg.sv
`default_nettype none

package vga_pkg;

  // Pixel colour packed as BBGGRR, two bits per channel
  typedef logic [5:0] rgb_t;

  // Pixel or line position, wide enough for the full 800x525 frame
  typedef logic [9:0] pos_t;

  // Default 640x480 geometry, used as the top-level parameter defaults
  localparam int H_VIEW  = 640;
  localparam int H_TOTAL = 800;
  localparam int V_VIEW  = 480;
  localparam int V_TOTAL = 525;

  // Sync pulse placement for the default geometry
  localparam int H_SYNC_START = 656;
  localparam int H_SYNC_WIDTH = 96;
  localparam int V_SYNC_START = 490;
  localparam int V_SYNC_WIDTH = 2;

endpackage

`default_nettype wire

//--- design/flash_pkg.sv
`default_nettype none

package flash_pkg;

  // Quad output fast read, data comes back on io[3:0] after 8 dummy clocks
  localparam logic [7:0] FLASH_CMD = 8'h6B;

  // Preamble lengths in sclk cycles
  localparam int CMD_LEN      = 8;
  localparam int ADDR_LEN     = 24;
  localparam int DUMMY_LEN    = 8;
  localparam int PREAMBLE_LEN = CMD_LEN + ADDR_LEN + DUMMY_LEN;

  // One slice is 64 texels of one byte each, read as two nibbles per texel
  localparam int TEXEL_COUNT = 64;
  localparam int READ_LEN    = TEXEL_COUNT * 2;
  localparam int STREAM_LEN  = PREAMBLE_LEN + READ_LEN;

  // A slice is 64 bytes, so the slice address sits at address bit 6 and up
  localparam int SLICE_SHIFT = 6;

  // Texel index within one slice
  typedef logic [5:0] texu_t;

  // Wall id, 0 means no wall on this line
  typedef logic [1:0] wall_id_t;

  // Slice address is {wall id - 1, side, texu}, sent as address bits 14 to 6
  typedef logic [8:0] slice_addr_t;

endpackage

`default_nettype wire

//--- design/vga_timing.sv
`default_nettype none

module vga_timing
  import vga_pkg::*;
#(
  parameter int H_VIEW  = vga_pkg::H_VIEW,
  parameter int H_TOTAL = vga_pkg::H_TOTAL,
  parameter int V_VIEW  = vga_pkg::V_VIEW,
  parameter int V_TOTAL = vga_pkg::V_TOTAL
) (
  input  logic clk,
  input  logic reset,
  output pos_t o_hpos,
  output pos_t o_vpos,
  output logic o_hsync_n,
  output logic o_vsync_n,
  output logic o_visible,
  output logic o_line_end,
  output logic o_frame_end
);

  // Front porch lengths of the default mode, kept when the geometry shrinks
  localparam int H_FRONT = vga_pkg::H_SYNC_START - vga_pkg::H_VIEW;
  localparam int V_FRONT = vga_pkg::V_SYNC_START - vga_pkg::V_VIEW;

  // If porch and pulse do not fit in the blank, the pulse starts right at the view end
  localparam int HS_BEG = (H_VIEW + H_FRONT + H_SYNC_WIDTH <= H_TOTAL) ?
                          H_VIEW + H_FRONT : H_VIEW;
  localparam int HS_END = (HS_BEG + H_SYNC_WIDTH <= H_TOTAL) ? HS_BEG + H_SYNC_WIDTH : H_TOTAL;
  localparam int VS_BEG = (V_VIEW + V_FRONT + V_SYNC_WIDTH <= V_TOTAL) ?
                          V_VIEW + V_FRONT : V_VIEW;
  localparam int VS_END = (VS_BEG + V_SYNC_WIDTH <= V_TOTAL) ? VS_BEG + V_SYNC_WIDTH : V_TOTAL;

  pos_t hpos;
  pos_t vpos;
  logic line_end;

  assign line_end = (hpos == pos_t'(H_TOTAL - 1));

  // Pixel counter wraps every line, line counter wraps every frame
  always_ff @(posedge clk) begin
    if (!reset) begin
      hpos <= '0;
      vpos <= '0;
    end else if (line_end) begin
      hpos <= '0;
      vpos <= (vpos == pos_t'(V_TOTAL - 1)) ? '0 : vpos + 1'b1;
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  assign o_hpos     = hpos;
  assign o_vpos     = vpos;
  assign o_line_end = line_end;

  // Both sync pulses are active low
  assign o_hsync_n = !((hpos >= pos_t'(HS_BEG)) && (hpos < pos_t'(HS_END)));
  assign o_vsync_n = !((vpos >= pos_t'(VS_BEG)) && (vpos < pos_t'(VS_END)));
  assign o_visible = (hpos < pos_t'(H_VIEW)) && (vpos < pos_t'(V_VIEW));

  // Last pixel of the last visible line, where new register values may load
  assign o_frame_end = line_end && (vpos == pos_t'(V_VIEW - 1));

endmodule

`default_nettype wire

//--- design/apb_regs.sv
`default_nettype none

module apb_regs
  import vga_pkg::*;
  import flash_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [2:0]  i_paddr,
  input  logic [15:0] i_pwdata,
  output logic [15:0] o_prdata,
  input  logic        i_frame_end,
  output rgb_t        o_sky,
  output rgb_t        o_floor,
  output wall_id_t    o_wall_id,
  output logic        o_side,
  output texu_t       o_texu,
  output pos_t        o_size,
  output logic [15:0] o_texa,
  output logic [5:0]  o_vshift
);

  // Pending copy, written by the host at any time
  rgb_t        p_sky;
  rgb_t        p_floor;
  wall_id_t    p_wall_id;
  logic        p_side;
  texu_t       p_texu;
  pos_t        p_size;
  logic [15:0] p_texa;
  logic [5:0]  p_vshift;
  logic        wr;

  // APB transfers complete in the access phase without wait states
  assign wr = i_psel && i_penable && i_pwrite;

  always_ff @(posedge clk) begin
    if (!reset) begin
      p_sky     <= '0;
      p_floor   <= '0;
      p_wall_id <= '0;
      p_side    <= 1'b0;
      p_texu    <= '0;
      p_size    <= '0;
      p_texa    <= '0;
      p_vshift  <= '0;
    end else if (wr) begin
      case (i_paddr)
        3'd0: p_sky <= i_pwdata[5:0];
        3'd1: p_floor <= i_pwdata[5:0];
        3'd2: {p_wall_id, p_side, p_texu} <= i_pwdata[8:0];
        3'd3: p_size <= i_pwdata[9:0];
        3'd4: p_texa <= i_pwdata;
        3'd5: p_vshift <= i_pwdata[5:0];
        default: ;
      endcase
    end
  end

  // Reads see the pending copy, so a write is visible before it takes effect
  always_comb begin
    o_prdata = '0;
    case (i_paddr)
      3'd0: o_prdata[5:0] = p_sky;
      3'd1: o_prdata[5:0] = p_floor;
      3'd2: o_prdata[8:0] = {p_wall_id, p_side, p_texu};
      3'd3: o_prdata[9:0] = p_size;
      3'd4: o_prdata = p_texa;
      3'd5: o_prdata[5:0] = p_vshift;
      default: o_prdata = '0;
    endcase
  end

  // Active copy only changes between frames, so no frame shows a mix of old and new
  always_ff @(posedge clk) begin
    if (!reset) begin
      o_sky     <= '0;
      o_floor   <= '0;
      o_wall_id <= '0;
      o_side    <= 1'b0;
      o_texu    <= '0;
      o_size    <= '0;
      o_texa    <= '0;
      o_vshift  <= '0;
    end else if (i_frame_end) begin
      o_sky     <= p_sky;
      o_floor   <= p_floor;
      o_wall_id <= p_wall_id;
      o_side    <= p_side;
      o_texu    <= p_texu;
      o_size    <= p_size;
      o_texa    <= p_texa;
      o_vshift  <= p_vshift;
    end
  end

endmodule

`default_nettype wire

//--- design/tex_fetch.sv
`default_nettype none

module tex_fetch
  import vga_pkg::*;
  import flash_pkg::*;
#(
  parameter int H_VIEW = vga_pkg::H_VIEW
) (
  input  logic       clk,
  input  logic       reset,
  input  pos_t       i_hpos,
  input  wall_id_t   i_wall_id,
  input  logic       i_side,
  input  texu_t      i_texu,
  output logic       o_tex_csb,
  output logic       o_tex_sclk,
  output logic       o_tex_out0,
  output logic       o_tex_oeb0,
  input  logic [3:0] i_tex_in,
  output logic       o_wr_en,
  output texu_t      o_wr_idx,
  output rgb_t       o_wr_texel
);

  // The preamble ends exactly where the visible part of the line ends
  localparam pos_t READ_START = pos_t'(H_VIEW - PREAMBLE_LEN);

  pos_t                state;
  slice_addr_t         slice_addr;
  logic [ADDR_LEN-1:0] flash_addr;
  logic [4:0]          addr_bit;
  logic [6:0]          nibble;
  logic                active;
  logic                data_present;
  logic [2:0]          lo_bits;
  logic                lo_valid;

  // Fetch state follows hpos, it wraps far above the stream length outside the window
  assign state        = i_hpos - READ_START;
  assign active       = (state < pos_t'(STREAM_LEN));
  assign data_present = active && (state >= pos_t'(PREAMBLE_LEN));
  assign nibble       = 7'(state - pos_t'(PREAMBLE_LEN));

  // Wall ids start at 1 while slices in the flash start at 0
  assign slice_addr = {wall_id_t'(i_wall_id - 1'b1), i_side, i_texu};
  assign flash_addr = ADDR_LEN'(slice_addr) << SLICE_SHIFT;
  assign addr_bit   = 5'(pos_t'(CMD_LEN + ADDR_LEN - 1) - state);

  // Chip select spans the whole stream and sclk only toggles while selected
  assign o_tex_csb  = !active;
  // Inverted clk lets io0 settle on rising clk before the flash samples it
  assign o_tex_sclk = ~clk & active;

  // Command then address go out MSB first, io0 turns around at the dummy phase
  always_comb begin
    if (state < pos_t'(CMD_LEN)) begin
      // Bit 7 minus state, which for three bits is the inverted state
      o_tex_out0 = FLASH_CMD[~state[2:0]];
    end else if (state < pos_t'(CMD_LEN + ADDR_LEN)) begin
      o_tex_out0 = flash_addr[addr_bit];
    end else begin
      o_tex_out0 = 1'b0;
    end
  end

  assign o_tex_oeb0 = active && (state >= pos_t'(CMD_LEN + ADDR_LEN));

  // Even nibble holds the low bit of R, G and B on io0 to io2, io3 is unused
  always_ff @(posedge clk) begin
    if (data_present && !nibble[0]) begin
      lo_bits <= i_tex_in[2:0];
    end
  end

  // Tracks that a low half is waiting for its odd nibble
  always_ff @(posedge clk) begin
    if (!reset) begin
      lo_valid <= 1'b0;
    end else if (data_present) begin
      lo_valid <= !nibble[0];
    end
  end

  // Odd nibble completes the texel, it is written in the same cycle
  assign o_wr_en    = data_present && nibble[0] && lo_valid;
  assign o_wr_idx   = nibble[6:1];
  assign o_wr_texel = {i_tex_in[2], lo_bits[2], i_tex_in[1], lo_bits[1],
                       i_tex_in[0], lo_bits[0]};

endmodule

`default_nettype wire

//--- design/texel_buffer.sv
`default_nettype none

module texel_buffer
  import vga_pkg::*;
  import flash_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  i_wr_en,
  input  texu_t i_wr_idx,
  input  rgb_t  i_wr_texel,
  input  texu_t i_rd_idx,
  output rgb_t  o_rd_texel
);

  // One wall slice, filled at the end of a line and shown on the next
  rgb_t mem [TEXEL_COUNT];

  // No texel is stored while the design is held in reset
  always_ff @(posedge clk) begin
    if (reset && i_wr_en) begin
      mem[i_wr_idx] <= i_wr_texel;
    end
  end

  // Asynchronous read so the shader gets the texel in the pixel's own cycle
  assign o_rd_texel = mem[i_rd_idx];

endmodule

`default_nettype wire

//--- design/wall_shader.sv
`default_nettype none

module wall_shader
  import vga_pkg::*;
  import flash_pkg::*;
#(
  parameter int H_VIEW = vga_pkg::H_VIEW
) (
  input  logic        clk,
  input  logic        reset,
  input  pos_t        i_hpos,
  input  logic        i_visible,
  input  logic        i_line_end,
  input  wall_id_t    i_wall_id,
  input  pos_t        i_size,
  input  logic [15:0] i_texa,
  input  logic [5:0]  i_vshift,
  input  rgb_t        i_sky,
  input  rgb_t        i_floor,
  output texu_t       o_rd_idx,
  input  rgb_t        i_rd_texel,
  output rgb_t        o_rgb
);

  // Centre of the line, the wall span is symmetric around it
  localparam int HALF = H_VIEW / 2;

  logic [15:0] tex_acc;
  logic [10:0] hpos_ext;
  logic [10:0] size_ext;
  logic        in_span;

  // Accumulator holds hpos times texa, truncated to 16 bits
  always_ff @(posedge clk) begin
    if (!reset || i_line_end) begin
      tex_acc <= '0;
    end else begin
      tex_acc <= tex_acc + i_texa;
    end
  end

  // Integer part above bit 10 plus the v-shift, wrapping inside the slice
  assign o_rd_idx = texu_t'(tex_acc[15:10] + i_vshift);

  // One extra bit so half-size may exceed the centre without underflow
  assign hpos_ext = {1'b0, i_hpos};
  assign size_ext = {1'b0, i_size};
  assign in_span  = (i_wall_id != '0) &&
                    (hpos_ext + size_ext >= 11'(HALF)) &&
                    (hpos_ext < 11'(HALF) + size_ext);

  // Floor fills the left half and sky the right half around the wall
  always_comb begin
    if (!i_visible) begin
      o_rgb = '0;
    end else if (in_span) begin
      o_rgb = i_rd_texel;
    end else if (i_hpos < pos_t'(HALF)) begin
      o_rgb = i_floor;
    end else begin
      o_rgb = i_sky;
    end
  end

endmodule

`default_nettype wire

//--- design/raycast_line.sv
`default_nettype none

module raycast_line
  import vga_pkg::*;
  import flash_pkg::*;
#(
  // H_TOTAL must leave at least 128 pixels of blank for the slice read
  parameter int H_VIEW  = vga_pkg::H_VIEW,
  parameter int H_TOTAL = vga_pkg::H_TOTAL,
  parameter int V_VIEW  = vga_pkg::V_VIEW,
  parameter int V_TOTAL = vga_pkg::V_TOTAL
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [2:0]  i_paddr,
  input  logic [15:0] i_pwdata,
  output logic [15:0] o_prdata,
  output logic        o_tex_csb,
  output logic        o_tex_sclk,
  output logic        o_tex_out0,
  output logic        o_tex_oeb0,
  input  logic [3:0]  i_tex_in,
  output logic        o_hsync_n,
  output logic        o_vsync_n,
  output logic        o_hblank,
  output logic        o_vblank,
  output rgb_t        o_rgb
);

  pos_t        hpos;
  pos_t        vpos;
  logic        visible;
  logic        line_end;
  logic        frame_end;
  rgb_t        sky;
  rgb_t        floor_rgb;
  wall_id_t    wall_id;
  logic        side;
  texu_t       texu;
  pos_t        size;
  logic [15:0] texa;
  logic [5:0]  vshift;
  logic        wr_en;
  texu_t       wr_idx;
  rgb_t        wr_texel;
  texu_t       rd_idx;
  rgb_t        rd_texel;

  // Blanking per axis, together they are the inverse of visible
  assign o_hblank = (hpos >= pos_t'(H_VIEW));
  assign o_vblank = (vpos >= pos_t'(V_VIEW));

  vga_timing #(
    .H_VIEW (H_VIEW),
    .H_TOTAL(H_TOTAL),
    .V_VIEW (V_VIEW),
    .V_TOTAL(V_TOTAL)
  ) u_timing (
    .clk        (clk),
    .reset      (reset),
    .o_hpos     (hpos),
    .o_vpos     (vpos),
    .o_hsync_n  (o_hsync_n),
    .o_vsync_n  (o_vsync_n),
    .o_visible  (visible),
    .o_line_end (line_end),
    .o_frame_end(frame_end)
  );

  // Host registers, the active set loads on the visible frame end
  apb_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .o_prdata   (o_prdata),
    .i_frame_end(frame_end),
    .o_sky      (sky),
    .o_floor    (floor_rgb),
    .o_wall_id  (wall_id),
    .o_side     (side),
    .o_texu     (texu),
    .o_size     (size),
    .o_texa     (texa),
    .o_vshift   (vshift)
  );

  // Reads the next line's slice during the horizontal blank
  tex_fetch #(
    .H_VIEW(H_VIEW)
  ) u_fetch (
    .clk       (clk),
    .reset     (reset),
    .i_hpos    (hpos),
    .i_wall_id (wall_id),
    .i_side    (side),
    .i_texu    (texu),
    .o_tex_csb (o_tex_csb),
    .o_tex_sclk(o_tex_sclk),
    .o_tex_out0(o_tex_out0),
    .o_tex_oeb0(o_tex_oeb0),
    .i_tex_in  (i_tex_in),
    .o_wr_en   (wr_en),
    .o_wr_idx  (wr_idx),
    .o_wr_texel(wr_texel)
  );

  texel_buffer u_buffer (
    .clk       (clk),
    .reset     (reset),
    .i_wr_en   (wr_en),
    .i_wr_idx  (wr_idx),
    .i_wr_texel(wr_texel),
    .i_rd_idx  (rd_idx),
    .o_rd_texel(rd_texel)
  );

  wall_shader #(
    .H_VIEW(H_VIEW)
  ) u_shader (
    .clk       (clk),
    .reset     (reset),
    .i_hpos    (hpos),
    .i_visible (visible),
    .i_line_end(line_end),
    .i_wall_id (wall_id),
    .i_size    (size),
    .i_texa    (texa),
    .i_vshift  (vshift),
    .i_sky     (sky),
    .i_floor   (floor_rgb),
    .o_rd_idx  (rd_idx),
    .i_rd_texel(rd_texel),
    .o_rgb     (o_rgb)
  );

endmodule

`default_nettype wire

//--- bench/raycast_checker.sv
`default_nettype none

module raycast_checker
  import vga_pkg::*;
  import flash_pkg::*;
(
  input logic clk,
  input logic reset,
  input pos_t i_state,
  input logic i_csb,
  input logic i_sclk,
  input logic i_out0,
  input logic i_oeb0
);

  // Quad fast-read opcode as the flash expects it
  localparam logic [7:0] CMD_EXP = 8'h6B;

  // Read by the testbench top when it adds up the result
  int failures = 0;

  // Chip select drops at the first fetch state of the stream
  csb_start: assert property (@(posedge clk) disable iff (!reset)
    $fell(i_csb) |-> (i_state == '0))
    else begin
      $error("csb falls outside fetch state 0");
      failures++;
    end

  // One stream is 168 states long, so csb rises again 168 cycles after it fell
  csb_length: assert property (@(posedge clk) disable iff (!reset)
    $fell(i_csb) |-> ##168 $rose(i_csb))
    else begin
      $error("csb is not low for exactly 168 states");
      failures++;
    end

  // Command goes out MSB first in states 0 to 7
  cmd_bits: assert property (@(posedge clk) disable iff (!reset)
    (i_state < pos_t'(8)) |-> (i_out0 == CMD_EXP[3'd7 - i_state[2:0]]))
    else begin
      $error("command bit on io0 is wrong");
      failures++;
    end

  // io0 is released 32 states into the stream when command and address are out
  oeb_turn: assert property (@(posedge clk) disable iff (!reset)
    $fell(i_csb) |-> ##32 $rose(i_oeb0))
    else begin
      $error("oeb0 does not rise at state 32");
      failures++;
    end

  // io0 is driven again only when the stream ends
  oeb_hold: assert property (@(posedge clk) disable iff (!reset)
    $fell(i_oeb0) |-> $rose(i_csb))
    else begin
      $error("oeb0 falls before csb rises");
      failures++;
    end

  // Every rising sclk edge lies inside a chip select window
  sclk_idle: assert property (@(posedge i_sclk) disable iff (!reset)
    !i_csb)
    else begin
      $error("sclk toggles while csb is high");
      failures++;
    end

endmodule

bind tex_fetch raycast_checker chk0 (
  .clk    (clk),
  .reset  (reset),
  .i_state(state),
  .i_csb  (o_tex_csb),
  .i_sclk (o_tex_sclk),
  .i_out0 (o_tex_out0),
  .i_oeb0 (o_tex_oeb0)
);

`default_nettype wire

//--- bench/line_scoreboard.sv
`default_nettype none

module line_scoreboard
  import vga_pkg::*;
  import flash_pkg::*;
#(
  parameter int H_VIEW  = vga_pkg::H_VIEW,
  parameter int H_TOTAL = vga_pkg::H_TOTAL,
  parameter int V_VIEW  = vga_pkg::V_VIEW,
  parameter int V_TOTAL = vga_pkg::V_TOTAL
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [2:0]  i_paddr,
  input  logic [15:0] i_pwdata,
  input  logic [15:0] i_prdata,
  input  logic        i_hsync_n,
  input  logic        i_vsync_n,
  input  logic        i_hblank,
  input  logic        i_vblank,
  input  rgb_t        i_rgb,
  input  logic [7:0]  i_image [32768],
  output int          o_errors,
  output int          o_checks
);

  // Porch and pulse of the default mode, the pulse moves to the view end if it does not fit
  localparam int HS_BEG = (H_VIEW + 112 <= H_TOTAL) ? H_VIEW + 16 : H_VIEW;
  localparam int HS_END = (HS_BEG + 96 <= H_TOTAL) ? HS_BEG + 96 : H_TOTAL;
  localparam int VS_BEG = (V_VIEW + 12 <= V_TOTAL) ? V_VIEW + 10 : V_VIEW;
  localparam int VS_END = (VS_BEG + 2 <= V_TOTAL) ? VS_BEG + 2 : V_TOTAL;

  int h;
  int v;
  int pend [6];
  int act [6];
  int slice_base;

  // Register widths from the map
  function automatic int reg_mask(int addr);
    case (addr)
      2: return 'h1FF;
      3: return 'h3FF;
      4: return 'hFFFF;
      default: return 'h3F;
    endcase
  endfunction

  // Even nibble (high half of the byte) holds the low bits of R, G and B
  function automatic rgb_t texel_of(logic [7:0] b);
    return {b[2], b[6], b[1], b[5], b[0], b[4]};
  endfunction

  function automatic rgb_t expect_pixel(int hp);
    int half;
    int idx;
    logic [15:0] acc;
    half = H_VIEW / 2;
    acc = 16'(hp * act[4]);
    idx = (int'(acc >> 10) + act[5]) % 64;
    if (hp >= H_VIEW || v >= V_VIEW) return '0;
    if (act[2][8:7] != 0 && hp >= half - act[3] && hp < half + act[3])
      return texel_of(i_image[slice_base + idx]);
    if (hp < half) return rgb_t'(act[1]);
    return rgb_t'(act[0]);
  endfunction

  // Own counters mirror the free running VGA counters, registers follow the APB bus
  always @(posedge clk) begin
    if (!reset) begin
      h <= 0;
      v <= 0;
      for (int i = 0; i < 6; i++) begin
        pend[i] <= 0;
        act[i] <= 0;
      end
    end else begin
      if (i_psel && i_penable && i_pwrite && i_paddr < 6)
        pend[i_paddr] <= i_pwdata & reg_mask(int'(i_paddr));
      // Frame end loads the active set
      if (h == H_TOTAL - 1 && v == V_VIEW - 1) act <= pend;
      // The slice fetched now is drawn on the next line
      if (h == H_VIEW)
        slice_base <= ((((act[2] >> 7) + 3) % 4) * 128 + act[2][6:0]) * 64;
      if (h == H_TOTAL - 1) begin
        h <= 0;
        v <= (v == V_TOTAL - 1) ? 0 : v + 1;
      end else begin
        h <= h + 1;
      end
    end
  end

  // Compare at the falling edge, where every output has settled
  always @(negedge clk) begin
    if (reset) begin
      if (i_psel && i_penable && !i_pwrite && i_paddr < 6) begin
        o_checks++;
        if (int'(i_prdata) != pend[i_paddr]) begin
          o_errors++;
          $display("error %0t: read of register %0d gave %h, expected %h",
                   $time, i_paddr, i_prdata, pend[i_paddr]);
        end
      end
      o_checks++;
      if (i_hblank != (h >= H_VIEW) || i_vblank != (v >= V_VIEW) ||
          i_hsync_n != !(h >= HS_BEG && h < HS_END) ||
          i_vsync_n != !(v >= VS_BEG && v < VS_END)) begin
        o_errors++;
        $display("error %0t: sync or blank wrong at line %0d pixel %0d", $time, v, h);
      end
      o_checks++;
      if (i_rgb !== expect_pixel(h)) begin
        o_errors++;
        $display("error %0t: rgb at line %0d pixel %0d is %h, expected %h",
                 $time, v, h, i_rgb, expect_pixel(h));
      end
    end
  end

  initial begin
    o_errors = 0;
    o_checks = 0;
    slice_base = 0;
  end

endmodule

`default_nettype wire

//--- bench/tb_top.sv
`default_nettype none

module clk_gen #(
  parameter int PERIOD = 20
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

endmodule

module tb_top
  import vga_pkg::*;
  import flash_pkg::*;
;

  // The shortened geometry still leaves 160 pixels of blank for the slice read
  localparam int HV = 200;
  localparam int HT = 360;
  localparam int VV = 4;
  localparam int VT = 6;
  localparam int FRAMES = 5;
  localparam int TIMEOUT = 3 * HT * VT;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [2:0]  paddr;
  logic [15:0] pwdata;
  logic [15:0] prdata;
  logic        csb;
  logic        sclk;
  logic        out0;
  logic        oeb0;
  logic [3:0]  tex_in;
  logic        hsync_n;
  logic        vsync_n;
  logic        hblank;
  logic        vblank;
  rgb_t        rgb;
  logic [7:0]  flash_mem [32768];
  logic [15:0] stim [FRAMES * 8];
  int          seed;
  int          errors;
  int          checks;
  int          fcnt;
  logic [7:0]  fcmd;
  logic [23:0] faddr;
  bit          ok;

  clk_gen #(.PERIOD(20)) clk0 (.o_clk(clk));

  raycast_line #(
    .H_VIEW (HV),
    .H_TOTAL(HT),
    .V_VIEW (VV),
    .V_TOTAL(VT)
  ) dut0 (
    .clk(clk), .reset(reset),
    .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
    .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata),
    .o_tex_csb(csb), .o_tex_sclk(sclk), .o_tex_out0(out0), .o_tex_oeb0(oeb0),
    .i_tex_in(tex_in),
    .o_hsync_n(hsync_n), .o_vsync_n(vsync_n),
    .o_hblank(hblank), .o_vblank(vblank), .o_rgb(rgb)
  );

  line_scoreboard #(.H_VIEW(HV), .H_TOTAL(HT), .V_VIEW(VV), .V_TOTAL(VT)) sb0 (
    .clk(clk), .reset(reset),
    .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
    .i_paddr(paddr), .i_pwdata(pwdata), .i_prdata(prdata),
    .i_hsync_n(hsync_n), .i_vsync_n(vsync_n),
    .i_hblank(hblank), .i_vblank(vblank), .i_rgb(rgb),
    .i_image(flash_mem), .o_errors(errors), .o_checks(checks)
  );

  // Flash model samples io0 on the falling clk edge, where sclk rises
  always @(negedge clk) begin
    int k;
    logic [7:0] b;
    k = fcnt - 40;
    b = flash_mem[15'(faddr + 24'(k / 2))];
    if (csb) begin
      fcnt <= 0;
    end else begin
      if (fcnt < 8) fcmd <= {fcmd[6:0], out0};
      if (fcnt >= 8 && fcnt < 32) faddr <= {faddr[22:0], out0};
      // Nibble k is held through state 40+k and the high half of the byte comes first
      if (fcnt >= 40) begin
        // Only the quad fast-read command gets an answer
        if (fcmd == 8'h6B) begin
          tex_in <= (k % 2 == 0) ? b[7:4] : b[3:0];
        end else begin
          tex_in <= 'z;
        end
      end
      fcnt <= fcnt + 1;
    end
  end

  task automatic apb_write(input logic [2:0] addr, input logic [15:0] data);
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk);
    #1 penable = 1'b1;
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [2:0] addr);
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clk);
    #1 penable = 1'b1;
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  // Returns at the start of the next vertical blank, or with found low on a timeout
  task automatic wait_vblank_start(output bit found);
    int n;
    int m;
    n = 0;
    m = 0;
    while (vblank && n < TIMEOUT) begin
      @(posedge clk);
      #1 n++;
    end
    while (!vblank && m < TIMEOUT) begin
      @(posedge clk);
      #1 m++;
    end
    found = (n < TIMEOUT) && (m < TIMEOUT);
  endtask

  initial begin
    seed = 43;
    for (int i = 0; i < 32768; i++) flash_mem[i] = 8'($random(seed));
    $readmemh("bench/stim_frames.txt", stim);
    reset = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    tex_in = '0;
    fcnt = 0;
    fcmd = '0;
    faddr = '0;
    ok = 1'b1;
    repeat (10) @(posedge clk);
    #1 reset = 1'b1;
    for (int f = 0; f < FRAMES && ok; f++) begin
      wait_vblank_start(ok);
      if (ok) begin
        apb_write(3'd0, stim[f * 8]);
        apb_write(3'd1, stim[f * 8 + 1]);
        apb_write(3'd2, {stim[f * 8 + 2][1:0], stim[f * 8 + 3][0], stim[f * 8 + 4][5:0]});
        apb_write(3'd3, stim[f * 8 + 5]);
        apb_write(3'd4, stim[f * 8 + 6]);
        apb_write(3'd5, stim[f * 8 + 7]);
        for (int a = 0; a < 6; a++) apb_read(3'(a));
      end
    end
    // The last values load at the next frame end and show on the frame after
    if (ok) wait_vblank_start(ok);
    if (ok) wait_vblank_start(ok);
    if (!ok) $display("Timed out waiting for the vertical blank");
    $display("Run finished: %0d checks, %0d mismatches, %0d assertion failures",
             checks, errors, dut0.u_fetch.chk0.failures);
    if (ok && errors == 0 && dut0.u_fetch.chk0.failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
design/vga_pkg.sv
design/flash_pkg.sv
design/vga_timing.sv
design/apb_regs.sv
design/tex_fetch.sv
design/texel_buffer.sv
design/wall_shader.sv
design/raycast_line.sv
bench/raycast_checker.sv
bench/line_scoreboard.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_top -o sim_tb \
  && ./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -q "All checks passed" \
  && echo "PASS" || { echo "FAIL"; exit 1; }

//--- bench/stim_frames.txt
// sky floor wall_id side texu size texa vshift, one frame per line, all hex
03 0c 1 0 05 28 0200 00
30 0f 2 1 3f 64 0100 07
15 2a 0 0 00 20 0400 00
3c 01 3 1 12 0a 1000 3f
00 3f 1 1 20 3c ffff 21
